/* rtl/mdio_pkg.sv */
`default_nettype none

package mdio_pkg;

    // MDC runs at clk / (2 * MDC_HALF_CYCLES), 2.5 MHz from a 25 MHz clk
    localparam int MDC_HALF_CYCLES = 5;

    // Clause-22 frame layout in MDC periods
    localparam int PREAMBLE_BITS = 32;
    localparam int HEADER_BITS = 14;
    localparam int DATA_BITS = 16;
    localparam int FRAME_BITS = 64;
    localparam int TURNAROUND_START = PREAMBLE_BITS + HEADER_BITS;
    localparam int DATA_START = FRAME_BITS - DATA_BITS;

    // Frame fields
    localparam logic [4:0] PHY_ADDRESS = 5'h0C;
    localparam logic [1:0] START_BITS = 2'b01;
    localparam logic [1:0] OP_READ = 2'b10;
    localparam logic [1:0] OP_WRITE = 2'b01;

    // AXI-Lite response code, the only one this slave returns
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [6:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [4:0] mdio_reg_addr_t;
    typedef logic [15:0] mdio_data_t;

    // Counters for the MDC half period and for the bits of one frame
    typedef logic [$clog2(MDC_HALF_CYCLES)-1:0] mdc_count_t;
    typedef logic [$clog2(FRAME_BITS):0] frame_count_t;

    // Signals driven by the AXI-Lite master
    typedef struct packed {
        logic awvalid;
        axil_addr_t awaddr;
        logic wvalid;
        axil_data_t wdata;
        logic bready;
        logic arvalid;
        axil_addr_t araddr;
        logic rready;
    } axil_req_t;

    // Signals driven back by the slave
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    // One management command handed from the front end to the frame engine
    typedef struct packed {
        logic is_read;
        mdio_reg_addr_t reg_addr;
        mdio_data_t wdata;
    } mdio_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        TURNAROUND,
        DATA,
        DONE
    } frame_state_t;

endpackage

`default_nettype wire

/* rtl/mdc_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module mdc_clock_gen
    import mdio_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic mdc_enable,
    output logic mdc,
    output logic mdc_rise,
    output logic mdc_fall
);

    // Counts clk cycles inside one MDC half period
    mdc_count_t half_count;

    // The strobes are registered together with mdc, so each one is high
    // exactly on the clk cycle where mdc shows its new level
    always_ff @(posedge clk) begin
        if (reset || !mdc_enable) begin
            // Parked low between frames so the PHY sees no stray edges
            half_count <= '0;
            mdc <= 1'b0;
            mdc_rise <= 1'b0;
            mdc_fall <= 1'b0;
        end else if (half_count == mdc_count_t'(MDC_HALF_CYCLES - 1)) begin
            half_count <= '0;
            // Since mdc starts low, the first toggle after enable is a rise
            mdc <= !mdc;
            mdc_rise <= !mdc;
            mdc_fall <= mdc;
        end else begin
            half_count <= half_count + 1'b1;
            // Strobes last a single clk cycle
            mdc_rise <= 1'b0;
            mdc_fall <= 1'b0;
        end
    end

    // Note the counter restarts from zero on every enable, so each frame
    // begins with a full half period of low MDC before the first rise

    // The frame engine only ever looks at the strobes and never at mdc
    // itself, which keeps all of its logic in the clk domain

endmodule

`default_nettype wire

/* rtl/mdio_axil_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_axil_slave
    import mdio_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,
    output logic       cmd_start,
    output mdio_cmd_t  cmd,
    input  logic       cmd_done,
    input  mdio_data_t rd_data
);

    // Transaction phase, only one transaction is ever in flight
    typedef enum logic [1:0] {
        PHASE_IDLE,
        PHASE_WDATA,
        PHASE_ISSUED,
        PHASE_RESP
    } phase_t;

    phase_t phase;
    logic bvalid;
    logic rvalid;
    axil_data_t rdata;

    logic awready;
    logic arready;
    logic wready;
    logic aw_fire;
    logic ar_fire;
    logic w_fire;
    logic b_fire;
    logic r_fire;

    // Both address channels are open only while idle
    assign arready = (phase == PHASE_IDLE);
    // A pending read blocks the write address so the read wins a tie
    assign awready = (phase == PHASE_IDLE) && !axil_req.arvalid;
    assign wready = (phase == PHASE_WDATA);

    assign ar_fire = arready && axil_req.arvalid;
    assign aw_fire = awready && axil_req.awvalid;
    assign w_fire = wready && axil_req.wvalid;
    assign b_fire = bvalid && axil_req.bready;
    assign r_fire = rvalid && axil_req.rready;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PHASE_IDLE;
            cmd_start <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            case (phase)
                PHASE_IDLE: begin
                    // A read has all it needs and starts the frame right away
                    if (ar_fire) begin
                        cmd_start <= 1'b1;
                        phase <= PHASE_ISSUED;
                    end else if (aw_fire) begin
                        phase <= PHASE_WDATA;
                    end
                end
                PHASE_WDATA: begin
                    if (w_fire) begin
                        cmd_start <= 1'b1;
                        phase <= PHASE_ISSUED;
                    end
                end
                PHASE_ISSUED: begin
                    // Wait for the frame engine to finish the serial frame
                    if (cmd_done) begin
                        bvalid <= !cmd.is_read;
                        rvalid <= cmd.is_read;
                        phase <= PHASE_RESP;
                    end
                end
                PHASE_RESP: begin
                    // Held until the master takes it
                    if (b_fire || r_fire) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        phase <= PHASE_IDLE;
                    end
                end
                default: phase <= PHASE_IDLE;
            endcase
        end
    end

    // Command fields, the register number sits in byte address bits 6..2
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            cmd.is_read <= 1'b1;
            cmd.reg_addr <= axil_req.araddr[6:2];
        end else if (aw_fire) begin
            cmd.is_read <= 1'b0;
            cmd.reg_addr <= axil_req.awaddr[6:2];
        end
        // Only the low half of the word goes out on the wire
        if (w_fire) begin
            cmd.wdata <= axil_req.wdata[15:0];
        end
        if (cmd_done && (phase == PHASE_ISSUED)) begin
            rdata <= axil_data_t'(rd_data);
        end
    end

    always_comb begin
        axil_rsp.awready = awready;
        axil_rsp.wready = wready;
        axil_rsp.bvalid = bvalid;
        axil_rsp.bresp = AXI_RESP_OKAY;
        axil_rsp.arready = arready;
        axil_rsp.rvalid = rvalid;
        axil_rsp.rdata = rdata;
        axil_rsp.rresp = AXI_RESP_OKAY;
    end

endmodule

`default_nettype wire

/* rtl/mdio_frame_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_frame_engine
    import mdio_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_start,
    input  mdio_cmd_t  cmd,
    input  logic       mdc_rise,
    input  logic       mdc_fall,
    output logic       mdc_enable,
    input  logic       mdio_i,
    output logic       mdio_o,
    output logic       mdio_t,
    output logic       cmd_done,
    output mdio_data_t rd_data
);

    frame_state_t state;

    // Number of bits already driven in this frame, one per MDC falling edge
    frame_count_t bit_count;

    // Start, opcode, PHY address and register address, sent MSB first
    logic [HEADER_BITS-1:0] header_sr;

    // Write data going out, or read data coming in, MSB first either way
    mdio_data_t data_sr;
    logic is_read;

    // MDC runs from the cycle after the command until the last rising edge
    assign mdc_enable = (state != IDLE) && (state != DONE);

    // DONE lasts exactly one cycle, so this is the completion pulse
    assign cmd_done = (state == DONE);

    assign rd_data = data_sr;

    // Frame payload, loaded on the command and shifted by the MDC strobes
    always_ff @(posedge clk) begin
        if ((state == IDLE) && cmd_start) begin
            is_read <= cmd.is_read;
            header_sr <= {START_BITS, (cmd.is_read ? OP_READ : OP_WRITE),
                          PHY_ADDRESS, cmd.reg_addr};
            data_sr <= cmd.wdata;
        end else if ((state == HEADER) && mdc_fall) begin
            header_sr <= {header_sr[HEADER_BITS-2:0], 1'b0};
        end else if ((state == DATA) && mdc_fall && !is_read) begin
            data_sr <= {data_sr[DATA_BITS-2:0], 1'b0};
        end else if ((state == DATA) && mdc_rise && is_read
                     && (bit_count > frame_count_t'(DATA_START))) begin
            // A rise right after a data bit was presented samples that bit
            data_sr <= {data_sr[DATA_BITS-2:0], mdio_i};
        end
    end

    // Bits change one clk after each falling edge, so they are stable well
    // before the PHY samples them on the next rising edge
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            bit_count <= '0;
            mdio_o <= 1'b0;
            mdio_t <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_start) begin
                        bit_count <= '0;
                        state <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    // The line is taken only at the first falling edge
                    if (mdc_fall) begin
                        mdio_o <= 1'b1;
                        mdio_t <= 1'b0;
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == frame_count_t'(PREAMBLE_BITS - 1)) begin
                            state <= HEADER;
                        end
                    end
                end
                HEADER: begin
                    if (mdc_fall) begin
                        mdio_o <= header_sr[HEADER_BITS-1];
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == frame_count_t'(TURNAROUND_START - 1)) begin
                            state <= TURNAROUND;
                        end
                    end
                end
                TURNAROUND: begin
                    if (mdc_fall) begin
                        if (is_read) begin
                            // Hand the line to the PHY for the rest of the frame
                            mdio_t <= 1'b1;
                        end else begin
                            // Write turnaround is a driven 1 then 0
                            mdio_t <= 1'b0;
                            mdio_o <= (bit_count == frame_count_t'(TURNAROUND_START));
                        end
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == frame_count_t'(DATA_START - 1)) begin
                            state <= DATA;
                        end
                    end
                end
                DATA: begin
                    if (mdc_fall) begin
                        // Reads keep the line released and only count
                        if (!is_read) begin
                            mdio_o <= data_sr[DATA_BITS-1];
                        end
                        bit_count <= bit_count + 1'b1;
                    end
                    // The rise after the last bit closes the frame
                    if (mdc_rise && (bit_count == frame_count_t'(FRAME_BITS))) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    mdio_o <= 1'b0;
                    mdio_t <= 1'b1;
                    state <= IDLE;
                end
                default: begin
                    mdio_t <= 1'b1;
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/mdio_master.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_master
    import mdio_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      mdio_i,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      mdc,
    output logic      mdio_o,
    output logic      mdio_t
);

    // Command path from the AXI-Lite front end to the frame engine
    logic cmd_start;
    mdio_cmd_t cmd;
    logic cmd_done;
    mdio_data_t rd_data;

    // MDC control and its edge strobes
    logic mdc_enable;
    logic mdc_rise;
    logic mdc_fall;

    mdio_axil_slave axil_slave0 (
        .clk       (clk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .cmd_done  (cmd_done),
        .rd_data   (rd_data)
    );

    mdio_frame_engine frame_engine0 (
        .clk        (clk),
        .reset      (reset),
        .cmd_start  (cmd_start),
        .cmd        (cmd),
        .mdc_rise   (mdc_rise),
        .mdc_fall   (mdc_fall),
        .mdc_enable (mdc_enable),
        .mdio_i     (mdio_i),
        .mdio_o     (mdio_o),
        .mdio_t     (mdio_t),
        .cmd_done   (cmd_done),
        .rd_data    (rd_data)
    );

    mdc_clock_gen mdc_gen0 (
        .clk        (clk),
        .reset      (reset),
        .mdc_enable (mdc_enable),
        .mdc        (mdc),
        .mdc_rise   (mdc_rise),
        .mdc_fall   (mdc_fall)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 40 ns period, 25 MHz to match the MDC divider in the package
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset is held for 8 rising edges and released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* verification/mdio_phy_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_phy_model
    import mdio_pkg::*;
(
    input  logic reset,
    input  logic mdc,
    input  logic mdio_o,
    input  logic mdio_t,
    output logic mdio_line
);

    mdio_data_t regs [0:31];
    logic [63:0] frame_log [0:31];
    int frame_count;
    int rise_count;
    int fall_count;
    logic [63:0] frame_sr;
    logic drive_en;
    logic drive_val;
    logic rd_frame;
    logic rd_match;
    mdio_reg_addr_t rd_reg;
    logic release_error;

    // Master wins when it drives, otherwise the PHY, otherwise the pull-up
    assign mdio_line = !mdio_t ? mdio_o : (drive_en ? drive_val : 1'b1);

    initial begin
        // Every register starts with a value built from its own address
        for (int i = 0; i < 32; i++) begin
            regs[i] = {3'b101, 5'(i), 3'b010, 5'(i)};
        end
        frame_count = 0;
        release_error = 1'b0;
    end

    // The first rise of a frame comes before any bit, so rise 65 ends the frame
    always @(posedge mdc) begin
        if (reset) begin
            rise_count = 0;
        end else begin
            rise_count = rise_count + 1;
            if (rise_count >= 2) begin
                frame_sr = {frame_sr[62:0], mdio_line};
            end
            // Bits 47 to 64 of a read belong to the PHY
            if (rd_frame && (rise_count >= 48) && !mdio_t) begin
                release_error = 1'b1;
            end
            if (rise_count == 65) begin
                frame_log[frame_count] = frame_sr;
                frame_count = frame_count + 1;
                if ((frame_sr[29:28] == OP_WRITE) && (frame_sr[27:23] == PHY_ADDRESS)) begin
                    regs[frame_sr[22:18]] = frame_sr[15:0];
                end
                rise_count = 0;
            end
        end
    end

    always @(negedge mdc) begin
        if (reset) begin
            fall_count = 0;
            drive_en = 1'b0;
            rd_frame = 1'b0;
            rd_match = 1'b0;
        end else begin
            fall_count = fall_count + 1;
            // Header bits 33 to 46 are all captured by now
            if (fall_count == 47) begin
                rd_frame = (frame_sr[11:10] == OP_READ);
                rd_match = rd_frame && (frame_sr[9:5] == PHY_ADDRESS);
                rd_reg = frame_sr[4:0];
            end
            if (rd_match && (fall_count == 48)) begin
                drive_en = 1'b1;
                drive_val = 1'b0;
            end
            if (rd_match && (fall_count >= 49) && (fall_count <= 64)) begin
                drive_val = regs[rd_reg][64-fall_count];
            end
            // The last data bit stays on the line until MDC is parked low,
            // and that parking fall closes the frame
            if (fall_count == 65) begin
                fall_count = 0;
                drive_en = 1'b0;
                rd_frame = 1'b0;
                rd_match = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/mdio_master_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_master_sva
    import mdio_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp,
    input logic      mdc,
    input logic      mdio_t
);

    // Only one transaction is in flight, so one response at a time
    one_response: assert property (@(posedge clk) disable iff (reset)
        !(axil_rsp.bvalid && axil_rsp.rvalid))
        else $error("bvalid and rvalid high together");

    // A read response is held with its data until it is taken
    rvalid_held: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid or rdata changed before rready");

    // Idle bus means a parked MDC and a released data line
    idle_line: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.awready |-> !mdc && mdio_t)
        else $error("MDIO line active while the slave is idle");

endmodule

bind mdio_master mdio_master_sva sva0 (
    .clk      (clk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .mdc      (mdc),
    .mdio_t   (mdio_t)
);

`default_nettype wire

/* verification/mdio_master_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mdio_master_tb
    import mdio_pkg::*;
();

    typedef enum logic [1:0] {
        OPC_WRITE,
        OPC_READ,
        OPC_BOTH
    } op_t;

    // A delay of 8'hFF asks for a random ready delay
    typedef struct packed {
        op_t op;
        axil_addr_t addr;
        mdio_data_t wdata;
        mdio_data_t rdata;
        logic [7:0] delay;
    } entry_t;

    logic clk;
    logic reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic mdc;
    logic mdio_o;
    logic mdio_t;
    logic mdio_line;
    entry_t stim [14];
    integer seed;
    int cycle_count;
    int limit;

    tb_clock clock0 (.clk(clk), .reset(reset));

    mdio_master dut0 (
        .clk      (clk),
        .reset    (reset),
        .mdio_i   (mdio_line),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .mdc      (mdc),
        .mdio_o   (mdio_o),
        .mdio_t   (mdio_t)
    );

    mdio_phy_model phy0 (
        .reset     (reset),
        .mdc       (mdc),
        .mdio_o    (mdio_o),
        .mdio_t    (mdio_t),
        .mdio_line (mdio_line)
    );

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // Clause-22 frame: preamble, start, opcode, PHY, register, turnaround, data
    function automatic logic [63:0] expected_frame(input logic is_read,
                                                   input mdio_reg_addr_t reg_addr,
                                                   input mdio_data_t data);
        return {32'hFFFF_FFFF, 2'b01, (is_read ? 2'b10 : 2'b01), 5'h0C, reg_addr, 2'b10, data};
    endfunction

    // Keeps ready low and watches that the response and the bus stay frozen
    task automatic hold_response(input int delay, input logic is_read);
        axil_data_t held;
        held = axil_rsp.rdata;
        repeat (delay) begin
            @(negedge clk);
            check_value("valid", 64'(is_read ? axil_rsp.rvalid : axil_rsp.bvalid), 64'd1);
            check_value("awready", 64'(axil_rsp.awready), 64'd0);
            check_value("arready", 64'(axil_rsp.arready), 64'd0);
            check_value("mdc", 64'(mdc), 64'd0);
            if (is_read) begin
                check_value("rdata", 64'(axil_rsp.rdata), 64'(held));
            end
        end
    endtask

    // Called right after a falling edge
    task automatic do_read(input axil_addr_t addr, input mdio_data_t expected, input int delay);
        axil_req.arvalid = 1'b1;
        axil_req.araddr = addr;
        while (!axil_rsp.arready) @(negedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) @(negedge clk);
        hold_response(delay, 1'b1);
        check_value("rdata", 64'(axil_rsp.rdata), {48'h0, expected});
        check_value("rresp", 64'(axil_rsp.rresp), 64'd0);
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic do_write(input axil_addr_t addr, input mdio_data_t data, input int delay);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr = addr;
        while (!axil_rsp.awready) @(negedge clk);
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        // The upper half is filled with junk that must not reach the wire
        axil_req.wvalid = 1'b1;
        axil_req.wdata = {~data, data};
        while (!axil_rsp.wready) @(negedge clk);
        @(negedge clk);
        axil_req.wvalid = 1'b0;
        while (!axil_rsp.bvalid) @(negedge clk);
        hold_response(delay, 1'b0);
        check_value("bresp", 64'(axil_rsp.bresp), 64'd0);
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    initial begin
        entry_t e;
        int d;
        int base;
        seed = 32'h76fd_55a5;
        axil_req = '0;
        stim[0] = '{OPC_READ, 7'h0C, 16'h0000, 16'hA343, 8'd0};
        stim[1] = '{OPC_WRITE, 7'h0C, 16'h1234, 16'h0000, 8'd0};
        stim[2] = '{OPC_READ, 7'h0C, 16'h0000, 16'h1234, 8'hFF};
        stim[3] = '{OPC_WRITE, 7'h1C, 16'hFFFF, 16'h0000, 8'hFF};
        stim[4] = '{OPC_READ, 7'h1C, 16'h0000, 16'hFFFF, 8'd0};
        stim[5] = '{OPC_WRITE, 7'h00, 16'h0000, 16'h0000, 8'd2};
        stim[6] = '{OPC_READ, 7'h00, 16'h0000, 16'h0000, 8'd0};
        stim[7] = '{OPC_WRITE, 7'h7C, 16'hA55A, 16'h0000, 8'hFF};
        stim[8] = '{OPC_READ, 7'h7C, 16'h0000, 16'hA55A, 8'd3};
        stim[9] = '{OPC_READ, 7'h30, 16'h0000, 16'hAC4C, 8'd0};
        // Read and write raised together, the read sees the old value
        stim[10] = '{OPC_BOTH, 7'h14, 16'h5A5A, 16'hA545, 8'hFF};
        stim[11] = '{OPC_READ, 7'h14, 16'h0000, 16'h5A5A, 8'd0};
        stim[12] = '{OPC_WRITE, 7'h50, 16'h8001, 16'h0000, 8'd1};
        stim[13] = '{OPC_READ, 7'h50, 16'h0000, 16'h8001, 8'hFF};
        @(negedge reset);
        @(negedge clk);
        check_value("awready", 64'(axil_rsp.awready), 64'd1);
        check_value("arready", 64'(axil_rsp.arready), 64'd1);
        check_value("wready", 64'(axil_rsp.wready), 64'd0);
        check_value("bvalid", 64'(axil_rsp.bvalid), 64'd0);
        check_value("rvalid", 64'(axil_rsp.rvalid), 64'd0);
        check_value("mdc", 64'(mdc), 64'd0);
        check_value("mdio_t", 64'(mdio_t), 64'd1);
        for (int i = 0; i < $size(stim); i++) begin
            e = stim[i];
            d = (e.delay == 8'hFF) ? ($random(seed) & 7) : int'(e.delay);
            base = phy0.frame_count;
            case (e.op)
                OPC_WRITE: begin
                    do_write(e.addr, e.wdata, d);
                    check_value("frame_count", 64'(phy0.frame_count), 64'(base + 1));
                    check_value("frame", phy0.frame_log[base],
                                expected_frame(1'b0, e.addr[6:2], e.wdata));
                    check_value("phy_reg", 64'(phy0.regs[e.addr[6:2]]), 64'(e.wdata));
                end
                OPC_READ: begin
                    do_read(e.addr, e.rdata, d);
                    check_value("frame_count", 64'(phy0.frame_count), 64'(base + 1));
                    check_value("frame", phy0.frame_log[base],
                                expected_frame(1'b1, e.addr[6:2], e.rdata));
                end
                default: begin
                    axil_req.awvalid = 1'b1;
                    axil_req.awaddr = e.addr;
                    do_read(e.addr, e.rdata, d);
                    do_write(e.addr, e.wdata, d);
                    check_value("frame_count", 64'(phy0.frame_count), 64'(base + 2));
                    check_value("first_frame", phy0.frame_log[base],
                                expected_frame(1'b1, e.addr[6:2], e.rdata));
                    check_value("second_frame", phy0.frame_log[base + 1],
                                expected_frame(1'b0, e.addr[6:2], e.wdata));
                end
            endcase
            check_value("release_error", 64'(phy0.release_error), 64'd0);
        end
        $display("=== PASS ===");
        $finish;
    end

    // A frame is about 650 cycles, so 700 per entry leaves room for delays
    initial begin
        cycle_count = 0;
        limit = $size(stim) * 700 + 200;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* mdio_master.f */
rtl/mdio_pkg.sv
rtl/mdc_clock_gen.sv
rtl/mdio_axil_slave.sv
rtl/mdio_frame_engine.sv
rtl/mdio_master.sv
verification/tb_clock.sv
verification/mdio_phy_model.sv
verification/mdio_master_sva.sv
verification/mdio_master_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mdio_master_tb
FILELIST ?= mdio_master.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
